/* Makefile */
TOP := ex1_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -o ex1_sim
	./obj_dir/ex1_sim | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* hdl/divider.sv */
module divider (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  logic        start_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic [31:0] quotient_o,
    output logic [31:0] remainder_o,
    output logic        stall_o,
    output logic        ready_o
);
    logic        busy_q;
    logic        ready_q;
    logic [5:0]  cnt_q;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvsr_q;
    logic        start_ok;
    logic        last;
    logic [32:0] trial;
    logic [33:0] diff;

    assign start_ok = start_i && !flush_i && !busy_q;
    assign last     = (cnt_q == 6'd32);

    // shift next dividend bit into the partial remainder
    assign trial = {rem_q, quo_q[31]};
    assign diff  = {1'b0, trial} - {2'b00, dvsr_q};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;
            if (busy_q) begin
                if (flush_i) begin
                    busy_q <= 1'b0;  // abandon, no ready
                end else if (last) begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 6'd1;
                end
            end else if (start_ok) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            rem_q  <= '0;
            quo_q  <= dividend_i;
            dvsr_q <= divisor_i;
        end else if (busy_q && !last) begin
            if (!diff[33]) begin  // no borrow, keep the difference
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;
    assign stall_o     = busy_q;
    assign ready_o     = ready_q;

endmodule

/* hdl/ex1_forward.sv */
module ex1_forward (
    input  logic [4:0]         rj_i,
    input  logic [4:0]         rk_i,
    input  logic [31:0]        rj_data_i,
    input  logic [31:0]        rk_data_i,
    input  pipe_pkg::fwd_src_t ex2_0_i,
    input  pipe_pkg::fwd_src_t ex2_1_i,
    input  pipe_pkg::fwd_src_t wb_0_i,
    input  pipe_pkg::fwd_src_t wb_1_i,
    output logic [31:0]        rj_data_o,
    output logic [31:0]        rk_data_o
);
    import pipe_pkg::*;

    // r0 is hardwired, never forward to it
    function automatic logic hit(input fwd_src_t src, input logic [4:0] r);
        return src.valid && (src.rd == r) && (r != 5'd0);
    endfunction

    // youngest first: ex2 lane 1, ex2 lane 0, wb lane 1, wb lane 0
    function automatic logic [31:0] resolve(
        input logic [4:0]  r,
        input logic [31:0] rf_data,
        input fwd_src_t    e1,
        input fwd_src_t    e0,
        input fwd_src_t    w1,
        input fwd_src_t    w0
    );
        if (hit(e1, r))      return e1.data;
        else if (hit(e0, r)) return e0.data;
        else if (hit(w1, r)) return w1.data;
        else if (hit(w0, r)) return w0.data;
        return rf_data;
    endfunction

    assign rj_data_o = resolve(rj_i, rj_data_i, ex2_1_i, ex2_0_i, wb_1_i, wb_0_i);
    assign rk_data_o = resolve(rk_i, rk_data_i, ex2_1_i, ex2_0_i, wb_1_i, wb_0_i);

endmodule

/* hdl/ex1_stage.sv */
module ex1_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  pipe_pkg::issue_slot_t lane0_i,
    input  pipe_pkg::issue_slot_t lane1_i,
    input  pipe_pkg::fwd_src_t    fwd_ex2_0_i,
    input  pipe_pkg::fwd_src_t    fwd_ex2_1_i,
    input  pipe_pkg::fwd_src_t    fwd_wb_0_i,
    input  pipe_pkg::fwd_src_t    fwd_wb_1_i,
    input  logic [31:0]           tid_i,
    input  logic [63:0]           stable_counter_i,
    input  logic                  predict_taken_i,
    input  logic [31:0]           predict_pc_i,
    output pipe_pkg::alu_res_t    res0_o,
    output pipe_pkg::alu_res_t    res1_o,
    output pipe_pkg::branch_res_t branch_o,
    output pipe_pkg::dcache_req_t dcache_req_o,
    output pipe_pkg::mul_part_t   mul_part_o,
    output logic [31:0]           quotient_o,
    output logic [31:0]           remainder_o,
    output logic                  div_stall_o,
    output logic                  div_ready_o
);
    import ex_pkg::*;

    logic [31:0] rj0_data;
    logic [31:0] rk0_data;
    logic [31:0] rj1_data;
    logic [31:0] rk1_data;
    logic [31:0] a0;
    logic [31:0] b0;
    logic [31:0] a1;
    logic [31:0] b1;
    logic [31:0] y0;
    logic [31:0] y1;
    logic [31:0] pc0_plus4;

    function automatic logic [31:0] pick_a(
        input logic [1:0]  sel,
        input logic [31:0] rf,
        input logic [31:0] pc,
        input logic [31:0] tid
    );
        case (sel)
            SRC1_RF:  return rf;
            SRC1_PC:  return pc;
            SRC1_TID: return tid;
            default:  return '0;  // SRC1_ZERO
        endcase
    endfunction

    function automatic logic [31:0] pick_b(
        input logic [1:0]  sel,
        input logic [31:0] rf,
        input logic [31:0] imm,
        input logic [63:0] cnt
    );
        case (sel)
            SRC2_RF:   return rf;
            SRC2_IMM:  return imm;
            SRC2_CNTL: return cnt[31:0];
            SRC2_CNTH: return cnt[63:32];
            default:   return '0;
        endcase
    endfunction

    ex1_forward u_fwd0 (
        .rj_i      (lane0_i.rj),
        .rk_i      (lane0_i.rk),
        .rj_data_i (lane0_i.rj_data),
        .rk_data_i (lane0_i.rk_data),
        .ex2_0_i   (fwd_ex2_0_i),
        .ex2_1_i   (fwd_ex2_1_i),
        .wb_0_i    (fwd_wb_0_i),
        .wb_1_i    (fwd_wb_1_i),
        .rj_data_o (rj0_data),
        .rk_data_o (rk0_data)
    );

    ex1_forward u_fwd1 (
        .rj_i      (lane1_i.rj),
        .rk_i      (lane1_i.rk),
        .rj_data_i (lane1_i.rj_data),
        .rk_data_i (lane1_i.rk_data),
        .ex2_0_i   (fwd_ex2_0_i),
        .ex2_1_i   (fwd_ex2_1_i),
        .wb_0_i    (fwd_wb_0_i),
        .wb_1_i    (fwd_wb_1_i),
        .rj_data_o (rj1_data),
        .rk_data_o (rk1_data)
    );

    assign a0 = pick_a(lane0_i.uop.src1_sel, rj0_data, lane0_i.pc, tid_i);
    assign b0 = pick_b(lane0_i.uop.src2_sel, rk0_data, lane0_i.imm, stable_counter_i);
    assign a1 = pick_a(lane1_i.uop.src1_sel, rj1_data, lane1_i.pc, tid_i);
    assign b1 = pick_b(lane1_i.uop.src2_sel, rk1_data, lane1_i.imm, stable_counter_i);

    ex_alu u_alu0 (.op_i(lane0_i.uop.cond), .a_i(a0), .b_i(b0), .y_o(y0));
    ex_alu u_alu1 (.op_i(lane1_i.uop.cond), .a_i(a1), .b_i(b1), .y_o(y1));

    // branches write the link address, lane 0 only
    assign pc0_plus4    = lane0_i.pc + 32'd4;
    assign res0_o.data  = lane0_i.uop.is_br ? pc0_plus4 : y0;
    assign res0_o.valid = lane0_i.uop.is_alu || lane0_i.uop.is_br;
    assign res1_o.data  = y1;
    assign res1_o.valid = lane1_i.uop.is_alu;

    ex_branch u_branch (
        .pc_i            (lane0_i.pc),
        .imm_i           (lane0_i.imm),
        .src1_i          (rj0_data),
        .src2_i          (rk0_data),
        .predict_pc_i    (predict_pc_i),
        .uop_i           (lane0_i.uop),
        .predict_taken_i (predict_taken_i),
        .branch_o        (branch_o)
    );

    mul_stage1 u_mul1 (
        .src1_i (rj0_data),
        .src2_i (rk0_data),
        .sign_i (lane0_i.uop.sign),
        .part_o (mul_part_o)
    );

    divider u_div (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .start_i     (lane0_i.uop.is_div),
        .dividend_i  (rj0_data),
        .divisor_i   (rk0_data),
        .quotient_o  (quotient_o),
        .remainder_o (remainder_o),
        .stall_o     (div_stall_o),
        .ready_o     (div_ready_o)
    );

    // data cache request from lane 0
    assign dcache_req_o.valid      = lane0_i.uop.is_mem;
    assign dcache_req_o.op         = lane0_i.uop.cond[2];
    assign dcache_req_o.atom       = lane0_i.uop.mem_atom;
    assign dcache_req_o.write_type = (lane0_i.uop.cond[1:0] == 2'd0) ? 4'b0001 :
                                     (lane0_i.uop.cond[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
    assign dcache_req_o.addr       = rj0_data + lane0_i.imm;
    assign dcache_req_o.wdata      = rk0_data;

endmodule

/* hdl/ex_alu.sv */
module ex_alu (
    input  logic [3:0]  op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic [31:0] y_o
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {31'b0, a_i < b_i};
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_NOR:  y_o = ~(a_i | b_i);
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = $unsigned($signed(a_i) >>> shamt);
            ALU_LUI:  y_o = b_i;  // imm comes pre-shifted
            default:  y_o = '0;
        endcase
    end

endmodule

/* hdl/ex_branch.sv */
module ex_branch (
    input  logic [31:0]           pc_i,
    input  logic [31:0]           imm_i,
    input  logic [31:0]           src1_i,
    input  logic [31:0]           src2_i,
    input  logic [31:0]           predict_pc_i,
    input  ex_pkg::uop_t          uop_i,
    input  logic                  predict_taken_i,
    output pipe_pkg::branch_res_t branch_o
);
    import ex_pkg::*;

    logic        cond_met;
    logic        taken;
    logic [31:0] target;

    always_comb begin
        case (uop_i.cond)
            BR_BEQ:  cond_met = (src1_i == src2_i);
            BR_BNE:  cond_met = (src1_i != src2_i);
            BR_BLT:  cond_met = ($signed(src1_i) < $signed(src2_i));
            BR_BGE:  cond_met = ($signed(src1_i) >= $signed(src2_i));
            BR_BLTU: cond_met = (src1_i < src2_i);
            BR_BGEU: cond_met = (src1_i >= src2_i);
            BR_B:    cond_met = 1'b1;
            BR_JIRL: cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    // jirl is register relative
    assign target = (uop_i.cond == BR_JIRL) ? src1_i + imm_i : pc_i + imm_i;
    assign taken  = uop_i.is_br && cond_met;

    assign branch_o.taken     = taken;
    assign branch_o.dir_fail  = uop_i.is_br && (taken != predict_taken_i);
    assign branch_o.addr_fail = taken && predict_taken_i && (target != predict_pc_i);
    assign branch_o.pc        = pc_i;
    assign branch_o.tpc       = target;

endmodule

/* hdl/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN = 32;

    typedef struct packed {
        logic [3:0] cond;      // alu op, branch cond or mem op and size
        logic [1:0] src1_sel;
        logic [1:0] src2_sel;
        logic       is_alu;
        logic       is_br;
        logic       is_mem;
        logic       is_div;
        logic       mem_atom;
        logic       sign;      // signed multiply
    } uop_t;

    // alu operations
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLT  = 4'd2;
    localparam logic [3:0] ALU_SLTU = 4'd3;
    localparam logic [3:0] ALU_AND  = 4'd4;
    localparam logic [3:0] ALU_OR   = 4'd5;
    localparam logic [3:0] ALU_XOR  = 4'd6;
    localparam logic [3:0] ALU_NOR  = 4'd7;
    localparam logic [3:0] ALU_SLL  = 4'd8;
    localparam logic [3:0] ALU_SRL  = 4'd9;
    localparam logic [3:0] ALU_SRA  = 4'd10;
    localparam logic [3:0] ALU_LUI  = 4'd11;

    localparam logic [1:0] SRC1_RF   = 2'd0;
    localparam logic [1:0] SRC1_PC   = 2'd1;
    localparam logic [1:0] SRC1_ZERO = 2'd2;
    localparam logic [1:0] SRC1_TID  = 2'd3;

    localparam logic [1:0] SRC2_RF   = 2'd0;
    localparam logic [1:0] SRC2_IMM  = 2'd1;
    localparam logic [1:0] SRC2_CNTL = 2'd2;  // stable counter low word
    localparam logic [1:0] SRC2_CNTH = 2'd3;

    // branch conditions
    localparam logic [3:0] BR_BEQ  = 4'd0;
    localparam logic [3:0] BR_BNE  = 4'd1;
    localparam logic [3:0] BR_BLT  = 4'd2;
    localparam logic [3:0] BR_BGE  = 4'd3;
    localparam logic [3:0] BR_BLTU = 4'd4;
    localparam logic [3:0] BR_BGEU = 4'd5;
    localparam logic [3:0] BR_B    = 4'd6;
    localparam logic [3:0] BR_JIRL = 4'd7;

endpackage

/* hdl/mul_stage1.sv */
module mul_stage1 (
    input  logic [31:0]         src1_i,
    input  logic [31:0]         src2_i,
    input  logic                sign_i,
    output pipe_pkg::mul_part_t part_o
);
    logic [31:0] fix1;
    logic [31:0] fix2;

    // unsigned 16x16 products of the halves
    assign part_o.hh = {16'b0, src1_i[31:16]} * {16'b0, src2_i[31:16]};
    assign part_o.hl = {16'b0, src1_i[31:16]} * {16'b0, src2_i[15:0]};
    assign part_o.lh = {16'b0, src1_i[15:0]} * {16'b0, src2_i[31:16]};
    assign part_o.ll = {16'b0, src1_i[15:0]} * {16'b0, src2_i[15:0]};

    // a negative operand costs 2^32 times the other one
    assign fix1 = (sign_i && src1_i[31]) ? src2_i : 32'd0;
    assign fix2 = (sign_i && src2_i[31]) ? src1_i : 32'd0;
    assign part_o.compensate = fix1 + fix2;  // wraps mod 2^32

endmodule

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    // one issue lane as it arrives from decode
    typedef struct packed {
        logic [ex_pkg::XLEN-1:0] pc;
        ex_pkg::uop_t            uop;
        logic [ex_pkg::XLEN-1:0] imm;
        logic [4:0]              rj;
        logic [4:0]              rk;
        logic [4:0]              rd;
        logic [ex_pkg::XLEN-1:0] rj_data;
        logic [ex_pkg::XLEN-1:0] rk_data;
    } issue_slot_t;

    typedef struct packed {
        logic [4:0]              rd;
        logic [ex_pkg::XLEN-1:0] data;
        logic                    valid;  // result already computed
    } fwd_src_t;

    typedef struct packed {
        logic [ex_pkg::XLEN-1:0] data;
        logic                    valid;
    } alu_res_t;

    typedef struct packed {
        logic                    dir_fail;
        logic                    addr_fail;
        logic                    taken;
        logic [ex_pkg::XLEN-1:0] pc;
        logic [ex_pkg::XLEN-1:0] tpc;
    } branch_res_t;

    typedef struct packed {
        logic                    valid;
        logic                    op;          // 0 read, 1 write
        logic                    atom;
        logic [3:0]              write_type;  // byte enables
        logic [ex_pkg::XLEN-1:0] addr;
        logic [ex_pkg::XLEN-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic [ex_pkg::XLEN-1:0] hh;
        logic [ex_pkg::XLEN-1:0] hl;
        logic [ex_pkg::XLEN-1:0] lh;
        logic [ex_pkg::XLEN-1:0] ll;
        logic [ex_pkg::XLEN-1:0] compensate;
    } mul_part_t;

endpackage

/* project.f */
hdl/ex_pkg.sv
hdl/pipe_pkg.sv
hdl/ex1_forward.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/mul_stage1.sv
hdl/divider.sv
hdl/ex1_stage.sv
verif/ex1_clkgen.sv
verif/ex1_props.sv
verif/ex1_tb.sv

/* verif/ex1_clkgen.sv */
module ex1_clkgen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk_o = 1'b0;

    always #2 clk_o = ~clk_o;  // 4 ns period

endmodule

/* verif/ex1_patterns.hex */
// id uop0 uop1 rj rk fwd(ex2_1 ex2_0 wb_1 wb_0) ctl predict_pc pc imm rj_data rk_data
// exp_res0 exp_res1 exp_aux0 exp_aux1 exp_flags; ctl = {write_type, flush, predict_taken}
01_0020_0020_01_02_81818282_00_00000000_00000000_00000000_00000010_00000020_00000600_00000600_00000000_00000000_c0
01_0020_0020_03_03_03838300_00_00000000_00000000_00000000_00000010_00000020_00000200_00000200_00000000_00000000_c0
01_0020_0020_00_04_80808084_00_00000000_00000000_00000000_00000010_00000020_00000310_00000310_00000000_00000000_c0
01_0020_0020_05_06_00000000_00_00000000_00000000_00000000_00000010_00000020_00000030_00000030_00000000_00000000_c0
02_0020_0420_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_800000f4_800000ec_00000000_00000000_c0
02_0820_0c20_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_00000001_00000000_00000000_00000000_c0
02_1020_1420_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_00000000_800000f4_00000000_00000000_c0
02_1820_1c20_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_800000f4_7fffff0b_00000000_00000000_c0
02_2020_2420_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_00000f00_0800000f_00000000_00000000_c0
02_2820_2c60_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_f800000f_12345000_00000000_00000000_c0
02_0160_02a0_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_22345000_00001000_00000000_00000000_c0
02_03e0_0000_01_02_00000000_00_00000000_10000000_12345000_800000f0_00000004_c0de0008_00000000_00000000_00000000_80
03_0010_0000_01_02_00000000_01_00002040_00002000_00000040_00000055_00000055_00002004_00000000_00002040_00000000_88
03_0410_0000_01_02_00000000_01_00002040_00002000_00000040_00000055_00000055_00002004_00000000_00002040_00000000_a0
03_0810_0000_01_02_00000000_00_00000000_00002000_00000040_ffffffff_00000001_00002004_00000000_00002040_00000000_a8
03_0c10_0000_01_02_00000000_00_00000000_00002000_00000040_ffffffff_00000001_00002004_00000000_00002040_00000000_80
03_1010_0000_01_02_00000000_01_00002040_00002000_00000040_ffffffff_00000001_00002004_00000000_00002040_00000000_a0
03_1410_0000_01_02_00000000_01_00003000_00002000_00000040_ffffffff_00000001_00002004_00000000_00002040_00000000_98
03_1810_0000_01_02_00000000_01_00002040_00002000_00000040_00000055_00000055_00002004_00000000_00002040_00000000_88
03_1c10_0000_01_02_00000000_01_00002040_00002000_00000040_00008000_00000000_00002004_00000000_00008040_00000000_98
04_0008_0000_01_02_00000000_10_00000000_00000000_00000003_00001000_deadbeef_00000000_00000000_00001003_deadbeef_04
04_1408_0000_01_02_00000000_30_00000000_00000000_fffffffc_00001000_deadbeef_00000000_00000000_00000ffc_deadbeef_06
04_080a_0000_01_02_00000000_f0_00000000_00000000_00000000_00001000_deadbeef_00000000_00000000_00001000_deadbeef_05
04_1808_0000_01_02_00000000_f0_00000000_00000000_00000010_00001000_deadbeef_00000000_00000000_00001010_deadbeef_06
05_0001_0000_01_02_00000000_00_00000000_00000000_00000000_ffffffff_ffffffff_00000000_00000000_00000000_00000000_00
05_0000_0000_01_02_00000000_00_00000000_00000000_00000000_ffffffff_ffffffff_00000000_00000000_00000000_00000000_00
05_0001_0000_01_02_00000000_00_00000000_00000000_00000000_80000000_7fffffff_00000000_00000000_00000000_00000000_00
06_0004_0000_01_02_00000000_00_00000000_00000000_00000000_00000064_00000007_00000000_00000000_0000000e_00000002_00
06_0004_0000_01_02_00000000_00_00000000_00000000_00000000_ffffffff_00000010_00000000_00000000_0fffffff_0000000f_00
06_0004_0000_01_02_00000000_00_00000000_00000000_00000000_00001234_00000000_00000000_00000000_ffffffff_00001234_00
06_0004_0000_01_02_00000000_02_00000000_00000000_00000000_000003e8_00000003_00000000_00000000_00000000_00000000_00

/* verif/ex1_props.sv */
module ex1_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic flush_i,
    input logic stall_i,
    input logic ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    ready_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_i |=> !ready_i)
        else $error("div_ready high for more than one cycle");

    // stall ends with ready unless a flush came first
    ready_ends_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_i |-> $fell(stall_i))
        else $error("div_ready without div_stall falling");

    stall_fall_has_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(stall_i) && !$past(flush_i) |-> ready_i)
        else $error("div_stall fell without div_ready");

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !stall_i && !ready_i)
        else $error("divider outputs high during reset");

    no_start_on_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(stall_i) |-> !$past(flush_i))
        else $error("divider started while flush was high");

endmodule

bind divider ex1_props u_div_props (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .stall_i (stall_o),
    .ready_i (ready_o)
);

/* verif/ex1_tb.sv */
module ex1_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ex_pkg::*;
    import pipe_pkg::*;

    localparam int DEPTH  = 64;
    localparam int N_RAND = 4;

    typedef struct packed {
        logic [7:0]  test;
        logic [15:0] uop0;
        logic [15:0] uop1;
        logic [7:0]  rj;
        logic [7:0]  rk;
        logic [31:0] fwd;   // ex2_1, ex2_0, wb_1, wb_0 as {valid, 2'b0, rd}
        logic [7:0]  ctl;   // {write_type, 2'b0, flush, predict_taken}
        logic [31:0] ppc;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rjd;
        logic [31:0] rkd;
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic [31:0] exp2;  // tpc, address or quotient
        logic [31:0] exp3;  // wdata or remainder
        logic [7:0]  eflags;
    } vec_t;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         pred_taken;
    logic [31:0]  pred_pc;
    logic         div_stall;
    logic         div_ready;
    logic [31:0]  quotient;
    logic [31:0]  remainder;
    issue_slot_t  lane0;
    issue_slot_t  lane1;
    fwd_src_t     e0;
    fwd_src_t     e1;
    fwd_src_t     w0;
    fwd_src_t     w1;
    alu_res_t     res0;
    alu_res_t     res1;
    branch_res_t  br;
    dcache_req_t  dc;
    mul_part_t    mp;
    logic [391:0] mem [DEPTH];
    vec_t         v;
    int           n_vec;
    int           n_div;
    int           cur;
    int           errors;
    int           terr;
    logic [31:0]  ra;
    logic [31:0]  rb;
    logic [63:0]  prod;
    logic [63:0]  model;
    time          limit;
    string        names [7] = '{"", "forwarding", "alu", "branch", "memory", "multiplier",
                                "divider"};

    ex1_clkgen u_clkgen (.clk_o(clk));

    ex1_stage u_ex1_stage (
        .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush), .lane0_i(lane0), .lane1_i(lane1),
        .fwd_ex2_0_i(e0), .fwd_ex2_1_i(e1), .fwd_wb_0_i(w0), .fwd_wb_1_i(w1),
        .tid_i(32'd7), .stable_counter_i(64'hc0de_0001_0000_1000),
        .predict_taken_i(pred_taken), .predict_pc_i(pred_pc), .res0_o(res0), .res1_o(res1),
        .branch_o(br), .dcache_req_o(dc), .mul_part_o(mp), .quotient_o(quotient),
        .remainder_o(remainder), .div_stall_o(div_stall), .div_ready_o(div_ready)
    );

    task automatic report(input string what, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        terr++;
        $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic end_test(input int id);
        $display("test %0d %s finished with %0d errors", id, names[id], terr);
        terr = 0;
    endtask

    task automatic drive(input vec_t x);
        lane0 = '0;
        lane0.pc = x.pc;
        lane0.uop = uop_t'(x.uop0[13:0]);
        lane0.imm = x.imm;
        lane0.rj = x.rj[4:0];
        lane0.rk = x.rk[4:0];
        lane0.rj_data = x.rjd;
        lane0.rk_data = x.rkd;
        lane1 = lane0;
        lane1.uop = uop_t'(x.uop1[13:0]);
        {e1.valid, e1.rd} = {x.fwd[31], x.fwd[28:24]};
        {e0.valid, e0.rd} = {x.fwd[23], x.fwd[20:16]};
        {w1.valid, w1.rd} = {x.fwd[15], x.fwd[12:8]};
        {w0.valid, w0.rd} = {x.fwd[7], x.fwd[4:0]};
        pred_taken = x.ctl[0];
        pred_pc = x.ppc;
    endtask

    // called 1 ns after an edge; ready is due 33 edges after the start edge
    task automatic run_div(input logic [31:0] a, input logic [31:0] b, input logic [31:0] q,
                           input logic [31:0] r, input logic abort);
        int n;
        lane0 = '0;
        lane0.uop.is_div = 1'b1;
        lane0.rj_data = a;
        lane0.rk_data = b;
        @(posedge clk);
        #1 lane0.uop.is_div = 1'b0;
        n = 0;
        if (abort) begin
            repeat (8) @(posedge clk);
            #1 flush = 1'b1;
            #2;
            if (!div_stall) report("stall before flush", div_stall, 1'b1);
            @(posedge clk);
            #1 lane0.uop.is_div = 1'b1;  // idle now, flush must block the start
            @(posedge clk);
            #1 flush = 1'b0;
            lane0.uop.is_div = 1'b0;
            repeat (40) begin
                #2;
                if (div_stall || div_ready) n++;
                @(posedge clk);
                #1;
            end
            if (n != 0) report("stall or ready after flush, cycles", n, 0);
        end else begin
            do begin
                @(posedge clk);
                n++;
                #3;
            end while (!div_ready && n < 64);
            if (n != 33) report("divider ready latency", n, 33);
            if (div_stall) report("stall with ready", div_stall, 0);
            if (quotient !== q) report("quotient", quotient, q);
            if (remainder !== r) report("remainder", remainder, r);
        end
    endtask

    initial begin
        void'($urandom(32'heea6_c747));
        rst_n = 1'b0;
        flush = 1'b0;
        pred_taken = 1'b0;
        pred_pc = '0;
        lane0 = '0;
        lane1 = '0;
        e0 = '{rd: 5'd0, data: 32'h100, valid: 1'b0};
        e1 = '{rd: 5'd0, data: 32'h200, valid: 1'b0};
        w0 = '{rd: 5'd0, data: 32'h300, valid: 1'b0};
        w1 = '{rd: 5'd0, data: 32'h400, valid: 1'b0};
        errors = 0;
        terr = 0;
        $readmemh("verif/ex1_patterns.hex", mem);
        n_vec = 0;
        n_div = 0;
        while (n_vec < DEPTH && !$isunknown(mem[n_vec]) && mem[n_vec][391:384] != 8'd0) begin
            if (mem[n_vec][391:384] == 8'd6) n_div++;
            n_vec++;
        end
        limit = (n_vec + 16 + 40 * (n_div + N_RAND)) * 8;  // 4 ns cycles, twice over
        fork
            begin
                #(limit);
                $display("timeout: the run did not finish within %0t", limit);
                $display("tests failed");
                $finish;
            end
        join_none
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            v = vec_t'(mem[i]);
            if (i > 0 && v.test != cur) end_test(cur);
            cur = v.test;
            @(posedge clk);
            #1;
            if (v.test == 8'd6) begin
                run_div(v.rjd, v.rkd, v.exp2, v.exp3, v.ctl[1]);
                continue;
            end
            drive(v);
            #2;
            if (res0.valid !== v.eflags[7]) report("lane 0 valid", res0.valid, v.eflags[7]);
            if (res1.valid !== v.eflags[6]) report("lane 1 valid", res1.valid, v.eflags[6]);
            if (v.eflags[7] && res0.data !== v.exp0) report("lane 0 result", res0.data, v.exp0);
            if (v.eflags[6] && res1.data !== v.exp1) report("lane 1 result", res1.data, v.exp1);
            if (v.test == 8'd3) begin
                if ({br.dir_fail, br.addr_fail, br.taken} !== v.eflags[5:3])
                    report("dir_fail addr_fail taken", {br.dir_fail, br.addr_fail, br.taken},
                           v.eflags[5:3]);
                if (br.tpc !== v.exp2) report("branch target", br.tpc, v.exp2);
                if (br.pc !== v.pc) report("branch pc", br.pc, v.pc);
            end
            if (v.test == 8'd4) begin
                if ({dc.valid, dc.op, dc.atom} !== v.eflags[2:0])
                    report("valid op atom", {dc.valid, dc.op, dc.atom}, v.eflags[2:0]);
                if (dc.write_type !== v.ctl[7:4]) report("write_type", dc.write_type, v.ctl[7:4]);
                if (dc.addr !== v.exp2) report("memory address", dc.addr, v.exp2);
                if (dc.wdata !== v.exp3) report("write data", dc.wdata, v.exp3);
            end
            if (v.test == 8'd5) begin
                prod = {32'b0, mp.ll} + ({32'b0, mp.hl} << 16) + ({32'b0, mp.lh} << 16)
                     + {mp.hh - mp.compensate, 32'b0};
                if (v.uop0[0]) model = $signed(v.rjd) * $signed(v.rkd);
                else model = v.rjd * v.rkd;
                if (prod !== model) report("rebuilt product", prod, model);
            end
        end
        for (int k = 0; k < N_RAND; k++) begin
            ra = $urandom();
            rb = $urandom() >> ($urandom() % 28);
            @(posedge clk);
            #1 run_div(ra, rb, (rb == 0) ? '1 : ra / rb, (rb == 0) ? ra : ra % rb, 1'b0);
        end
        end_test(cur);
        $display("%0d vectors and %0d random divides run, %0d errors", n_vec, N_RAND, errors);
        if (errors == 0) $display("all tests passed");
        else $display("tests failed");
        $finish;
    end

endmodule
